//--- source/vchess_ctrl_pkg.sv
package vchess_ctrl_pkg;

   // Bus and datapath widths
   localparam int AXI_ADDR_WIDTH = 40;
   localparam int REG_INDEX_WIDTH = 14; // Byte address bits 15:2
   localparam int SIDE_WIDTH = 32;
   localparam int BOARD_SLICES = 8;
   localparam int BOARD_WIDTH = SIDE_WIDTH * BOARD_SLICES;
   localparam int EVAL_WIDTH = 24;
   localparam int MOVE_INDEX_WIDTH = 7;
   localparam int HALF_MOVE_WIDTH = 7;
   localparam int UCI_WIDTH = 16;

   // Register map, word indices
   localparam logic [REG_INDEX_WIDTH-1:0] REG_CONTROL = 14'd0;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_MOVE_INDEX = 14'd1;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_GAME_STATE = 14'd2;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_HALF_MOVE = 14'd3;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_QUIESCENCE = 14'd4;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_BOARD_BASE = 14'd8; // Eight slices follow
   localparam logic [REG_INDEX_WIDTH-1:0] REG_MOVE_EVAL = 14'd134;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_MOVE_COUNT = 14'd135;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_INITIAL_EVAL = 14'd136;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_UCI = 14'd139;

   typedef struct packed
   {
      logic white_to_move;
      logic [3:0] castle_mask;
      logic [3:0] en_passant_col; // Column of the pawn that may be taken en passant
   } game_state_fields_t;

   // Same 9 bits, raw for the bus and decoded for the generator
   typedef union packed
   {
      logic [8:0] raw;
      game_state_fields_t fields;
   } game_state_u;

endpackage

//--- source/ctrl_regs_if.sv
`timescale 1ns/10ps

interface ctrl_regs_if;

   logic [vchess_ctrl_pkg::BOARD_WIDTH-1:0] board;
   vchess_ctrl_pkg::game_state_u game_state;
   logic [vchess_ctrl_pkg::HALF_MOVE_WIDTH-1:0] half_move;
   logic [vchess_ctrl_pkg::MOVE_INDEX_WIDTH-1:0] move_index;
   logic new_board_valid;
   logic clear_moves;
   logic quiescence_moves;
   logic soft_reset;

   modport source
   (
      output board, game_state, half_move, move_index,
      output new_board_valid, clear_moves, quiescence_moves, soft_reset
   );

   modport sink
   (
      input board, game_state, half_move, move_index,
      input new_board_valid, clear_moves, quiescence_moves, soft_reset
   );

endinterface

//--- source/axi_lite_write.sv
`timescale 1ns/10ps

module axi_lite_write
(
   input logic clk,
   input logic reset,
   input logic [vchess_ctrl_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
   input logic awvalid,
   output logic awready,
   input logic [31:0] wdata,
   input logic wvalid,
   output logic wready,
   output logic bvalid,
   output logic [1:0] bresp,
   input logic bready,
   output logic wr_valid,
   output logic [vchess_ctrl_pkg::REG_INDEX_WIDTH-1:0] wr_index,
   output logic [31:0] wr_data
);

   logic aw_held;
   logic w_held;
   logic [vchess_ctrl_pkg::REG_INDEX_WIDTH-1:0] index_q;
   logic [31:0] data_q;

   // Both channels closed while a beat is held or a response waits
   assign awready = !aw_held && !bvalid;
   assign wready = !w_held && !bvalid;
   assign bresp = 2'b00; // Always OKAY

   assign wr_index = index_q;
   assign wr_data = data_q;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         aw_held <= 1'b0;
         w_held <= 1'b0;
         wr_valid <= 1'b0;
         bvalid <= 1'b0;
      end
      else
      begin
         wr_valid <= aw_held && w_held && !wr_valid; // Single pulse per write
         if (wr_valid)
         begin
            aw_held <= 1'b0;
            w_held <= 1'b0;
            bvalid <= 1'b1; // Register updates on this same edge
         end
         else
         begin
            if (awvalid && awready)
               aw_held <= 1'b1;
            if (wvalid && wready)
               w_held <= 1'b1;
         end
         if (bvalid && bready)
            bvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (awvalid && awready)
         index_q <= awaddr[vchess_ctrl_pkg::REG_INDEX_WIDTH+1:2]; // Word index
      if (wvalid && wready)
         data_q <= wdata;
   end

endmodule

//--- source/control_regs.sv
`timescale 1ns/10ps

module control_regs
(
   input logic clk,
   input logic reset,
   input logic wr_valid,
   input logic [vchess_ctrl_pkg::REG_INDEX_WIDTH-1:0] wr_index,
   input logic [31:0] wr_data,
   ctrl_regs_if.source regs,
   output logic new_board_valid,
   output logic clear_moves,
   output logic soft_reset,
   output logic quiescence_moves,
   output logic [vchess_ctrl_pkg::MOVE_INDEX_WIDTH-1:0] move_index,
   output logic white_to_move,
   output logic [3:0] castle_mask,
   output logic [3:0] en_passant_col,
   output logic [vchess_ctrl_pkg::HALF_MOVE_WIDTH-1:0] half_move,
   output logic [vchess_ctrl_pkg::BOARD_WIDTH-1:0] new_board
);

   logic new_board_valid_q;
   logic clear_moves_q;
   logic soft_reset_q;
   logic quiescence_q;
   logic [vchess_ctrl_pkg::MOVE_INDEX_WIDTH-1:0] move_index_q;
   logic [vchess_ctrl_pkg::HALF_MOVE_WIDTH-1:0] half_move_q;
   logic [vchess_ctrl_pkg::BOARD_WIDTH-1:0] board_q;
   vchess_ctrl_pkg::game_state_u game_state_q;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         new_board_valid_q <= 1'b0;
         clear_moves_q <= 1'b0;
         soft_reset_q <= 1'b0;
         quiescence_q <= 1'b0;
         move_index_q <= '0;
         half_move_q <= '0;
         board_q <= '0;
         game_state_q <= '0;
      end
      else if (wr_valid)
      begin
         case (wr_index)
            vchess_ctrl_pkg::REG_CONTROL:
            begin
               new_board_valid_q <= wr_data[0];
               clear_moves_q <= wr_data[1];
               soft_reset_q <= wr_data[31];
            end
            vchess_ctrl_pkg::REG_MOVE_INDEX:
               move_index_q <= wr_data[vchess_ctrl_pkg::MOVE_INDEX_WIDTH-1:0];
            vchess_ctrl_pkg::REG_GAME_STATE:
               game_state_q.raw <= wr_data[8:0];
            vchess_ctrl_pkg::REG_HALF_MOVE:
               half_move_q <= wr_data[vchess_ctrl_pkg::HALF_MOVE_WIDTH-1:0];
            vchess_ctrl_pkg::REG_QUIESCENCE:
               quiescence_q <= wr_data[0];
            default:
            begin
               // Board slices, anything else is dropped
               for (int k = 0; k < vchess_ctrl_pkg::BOARD_SLICES; k++)
                  if (wr_index == vchess_ctrl_pkg::REG_BOARD_BASE + k)
                     board_q[k*vchess_ctrl_pkg::SIDE_WIDTH +: vchess_ctrl_pkg::SIDE_WIDTH]
                        <= wr_data;
            end
         endcase
      end
   end

   assign regs.board = board_q;
   assign regs.game_state = game_state_q;
   assign regs.half_move = half_move_q;
   assign regs.move_index = move_index_q;
   assign regs.new_board_valid = new_board_valid_q;
   assign regs.clear_moves = clear_moves_q;
   assign regs.quiescence_moves = quiescence_q;
   assign regs.soft_reset = soft_reset_q;

   assign new_board_valid = new_board_valid_q;
   assign clear_moves = clear_moves_q;
   assign soft_reset = soft_reset_q;
   assign quiescence_moves = quiescence_q;
   assign move_index = move_index_q;
   assign half_move = half_move_q;
   assign new_board = board_q;
   assign white_to_move = game_state_q.fields.white_to_move; // Decoded view
   assign castle_mask = game_state_q.fields.castle_mask;
   assign en_passant_col = game_state_q.fields.en_passant_col;

endmodule

//--- source/status_read.sv
`timescale 1ns/10ps

module status_read
(
   input logic clk,
   input logic reset,
   input logic [vchess_ctrl_pkg::AXI_ADDR_WIDTH-1:0] araddr,
   input logic arvalid,
   output logic arready,
   output logic [31:0] rdata,
   output logic rvalid,
   output logic [1:0] rresp,
   input logic rready,
   ctrl_regs_if.sink regs,
   input logic am_idle,
   input logic am_moves_ready, // All moves generated
   input logic am_move_ready, // Move at move_index valid
   input logic initial_mate,
   input logic initial_stalemate,
   input logic initial_thrice_rep,
   input logic initial_fifty_move,
   input logic initial_insufficient_material,
   input logic initial_board_check,
   input logic [vchess_ctrl_pkg::MOVE_INDEX_WIDTH-1:0] am_move_count,
   input logic signed [vchess_ctrl_pkg::EVAL_WIDTH-1:0] initial_eval, // Root eval
   input logic signed [vchess_ctrl_pkg::EVAL_WIDTH-1:0] am_eval,
   input logic [vchess_ctrl_pkg::UCI_WIDTH-1:0] am_uci
);

   logic [vchess_ctrl_pkg::REG_INDEX_WIDTH-1:0] rd_index;
   logic [31:0] status_word;
   logic [31:0] read_word;

   function automatic logic [31:0] sign_extend
   (
      input logic [vchess_ctrl_pkg::EVAL_WIDTH-1:0] eval
   );
      sign_extend = {{(32 - vchess_ctrl_pkg::EVAL_WIDTH){eval[vchess_ctrl_pkg::EVAL_WIDTH-1]}},
                     eval};
   endfunction

   assign rd_index = araddr[vchess_ctrl_pkg::REG_INDEX_WIDTH+1:2];
   assign arready = !rvalid || rready; // Free slot or slot emptying now
   assign rresp = 2'b00;

   assign status_word = {regs.soft_reset, 20'b0,
                         initial_board_check, initial_insufficient_material,
                         initial_fifty_move, am_idle, initial_thrice_rep,
                         initial_mate, initial_stalemate,
                         am_move_ready, am_moves_ready,
                         regs.clear_moves, regs.new_board_valid};

   always_comb
   begin
      read_word = '0;
      case (rd_index)
         vchess_ctrl_pkg::REG_CONTROL: read_word = status_word;
         vchess_ctrl_pkg::REG_MOVE_INDEX: read_word = 32'(regs.move_index);
         vchess_ctrl_pkg::REG_GAME_STATE: read_word = 32'(regs.game_state.raw);
         vchess_ctrl_pkg::REG_HALF_MOVE: read_word = 32'(regs.half_move);
         vchess_ctrl_pkg::REG_QUIESCENCE: read_word = 32'(regs.quiescence_moves);
         vchess_ctrl_pkg::REG_MOVE_EVAL: read_word = sign_extend(am_eval);
         vchess_ctrl_pkg::REG_MOVE_COUNT: read_word = 32'(am_move_count);
         vchess_ctrl_pkg::REG_INITIAL_EVAL: read_word = sign_extend(initial_eval);
         vchess_ctrl_pkg::REG_UCI:
            // Promotion nibble, then each square coordinate behind a zero bit
            read_word = 32'({am_uci[15:12], 1'b0, am_uci[11:9], 1'b0, am_uci[8:6],
                             1'b0, am_uci[5:3], 1'b0, am_uci[2:0]});
         default:
         begin
            for (int k = 0; k < vchess_ctrl_pkg::BOARD_SLICES; k++)
               if (rd_index == vchess_ctrl_pkg::REG_BOARD_BASE + k)
                  read_word = regs.board[k*vchess_ctrl_pkg::SIDE_WIDTH +:
                                         vchess_ctrl_pkg::SIDE_WIDTH];
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         rvalid <= 1'b0;
      else if (arvalid && arready)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;
   end

   // Held until the master takes it
   always_ff @(posedge clk)
   begin
      if (arvalid && arready)
         rdata <= read_word;
   end

endmodule

//--- source/vchess_ctrl.sv
`timescale 1ns/10ps

module vchess_ctrl
(
   input logic clk,
   input logic reset,

   input logic [vchess_ctrl_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
   input logic [2:0] awprot, // Accepted and ignored
   input logic awvalid,
   output logic awready,
   input logic [31:0] wdata,
   input logic [3:0] wstrb, // Full word always written
   input logic wvalid,
   output logic wready,
   output logic [1:0] bresp,
   output logic bvalid,
   input logic bready,
   input logic [vchess_ctrl_pkg::AXI_ADDR_WIDTH-1:0] araddr,
   input logic [2:0] arprot,
   input logic arvalid,
   output logic arready,
   output logic [31:0] rdata,
   output logic [1:0] rresp,
   output logic rvalid,
   input logic rready,

   output logic soft_reset,
   output logic new_board_valid,
   output logic clear_moves,
   output logic quiescence_moves,
   output logic [vchess_ctrl_pkg::MOVE_INDEX_WIDTH-1:0] move_index,
   output logic white_to_move,
   output logic [3:0] castle_mask,
   output logic [3:0] en_passant_col,
   output logic [vchess_ctrl_pkg::HALF_MOVE_WIDTH-1:0] half_move,
   output logic [vchess_ctrl_pkg::BOARD_WIDTH-1:0] new_board,

   input logic am_idle,
   input logic am_moves_ready,
   input logic am_move_ready,
   input logic initial_mate,
   input logic initial_stalemate,
   input logic initial_thrice_rep,
   input logic initial_fifty_move,
   input logic initial_insufficient_material,
   input logic initial_board_check,
   input logic [vchess_ctrl_pkg::MOVE_INDEX_WIDTH-1:0] am_move_count,
   input logic signed [vchess_ctrl_pkg::EVAL_WIDTH-1:0] initial_eval,
   input logic signed [vchess_ctrl_pkg::EVAL_WIDTH-1:0] am_eval,
   input logic [vchess_ctrl_pkg::UCI_WIDTH-1:0] am_uci
);

   logic wr_valid;
   logic [vchess_ctrl_pkg::REG_INDEX_WIDTH-1:0] wr_index;
   logic [31:0] wr_data;

   ctrl_regs_if regs_bus ();

   axi_lite_write write_ch0
   (
      .clk (clk),
      .reset (reset),
      .awaddr (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata (wdata),
      .wvalid (wvalid),
      .wready (wready),
      .bvalid (bvalid),
      .bresp (bresp),
      .bready (bready),
      .wr_valid (wr_valid),
      .wr_index (wr_index),
      .wr_data (wr_data)
   );

   control_regs regs0
   (
      .clk (clk),
      .reset (reset),
      .wr_valid (wr_valid),
      .wr_index (wr_index),
      .wr_data (wr_data),
      .regs (regs_bus.source),
      .new_board_valid (new_board_valid),
      .clear_moves (clear_moves),
      .soft_reset (soft_reset),
      .quiescence_moves (quiescence_moves),
      .move_index (move_index),
      .white_to_move (white_to_move),
      .castle_mask (castle_mask),
      .en_passant_col (en_passant_col),
      .half_move (half_move),
      .new_board (new_board)
   );

   status_read read_ch0
   (
      .clk (clk),
      .reset (reset),
      .araddr (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rdata (rdata),
      .rvalid (rvalid),
      .rresp (rresp),
      .rready (rready),
      .regs (regs_bus.sink),
      .am_idle (am_idle),
      .am_moves_ready (am_moves_ready),
      .am_move_ready (am_move_ready),
      .initial_mate (initial_mate),
      .initial_stalemate (initial_stalemate),
      .initial_thrice_rep (initial_thrice_rep),
      .initial_fifty_move (initial_fifty_move),
      .initial_insufficient_material (initial_insufficient_material),
      .initial_board_check (initial_board_check),
      .am_move_count (am_move_count),
      .initial_eval (initial_eval),
      .am_eval (am_eval),
      .am_uci (am_uci)
   );

endmodule

//--- verification/ctrl_checker.sv
`timescale 1ns/10ps

module ctrl_checker
(
   input logic clk,
   input logic awready, wready, bvalid, rvalid, rready,
   input logic bready, arready,
   input logic [1:0] bresp, rresp,
   input logic [31:0] rdata,
   input logic soft_reset, new_board_valid, clear_moves, quiescence_moves,
   input logic white_to_move,
   input logic [3:0] castle_mask, en_passant_col,
   input logic [vchess_ctrl_pkg::MOVE_INDEX_WIDTH-1:0] move_index,
   input logic [vchess_ctrl_pkg::HALF_MOVE_WIDTH-1:0] half_move,
   input logic [vchess_ctrl_pkg::BOARD_WIDTH-1:0] new_board
);

   int errors = 0;
   logic [31:0] expected_reads[$];
   logic held_valid = 1'b0; // R beat stalled at the last edge
   logic [31:0] held_data;

   task automatic report_failure(input string msg);
      errors++;
      $display("CHECK FAILED at %0t: %s", $time, msg);
   endtask

   task automatic expect_read(input logic [31:0] value);
      expected_reads.push_back(value);
   endtask

   // Control outputs grouped like the register at that index
   function automatic logic [31:0] output_view(input int index);
      case (index)
         0: output_view = {soft_reset, 29'b0, clear_moves, new_board_valid};
         1: output_view = 32'(move_index);
         2: output_view = {23'b0, white_to_move, castle_mask, en_passant_col};
         3: output_view = 32'(half_move);
         4: output_view = {31'b0, quiescence_moves};
         default: output_view = (index >= 8 && index < 16) ? new_board[(index-8)*32 +: 32] : 'x;
      endcase
   endfunction

   task automatic check_outputs(input int index, input logic [31:0] expected);
      logic [31:0] seen;
      @(negedge clk);
      seen = output_view(index);
      if (seen !== expected)
         report_failure($sformatf("outputs for index %0d are %h, expected %h",
                                  index, seen, expected));
   endtask

   task automatic check_idle();
      @(negedge clk);
      if (bvalid !== 1'b0 || rvalid !== 1'b0 || awready !== 1'b1 || wready !== 1'b1
          || arready !== 1'b1)
         report_failure("bus handshake outputs not idle after reset");
   endtask

   always @(posedge clk)
   begin
      if (bvalid && (awready || wready))
         report_failure("write channel open while a response waits");
      if (rvalid && !rready && arready)
         report_failure("read address channel open while a response waits");
      if (bvalid && bready && bresp !== 2'b00)
         report_failure($sformatf("write response %b, expected OKAY", bresp));
      if (held_valid && (rvalid !== 1'b1 || rdata !== held_data))
         report_failure("read response changed before it was accepted");
      if (rvalid && rready)
      begin
         if (rresp !== 2'b00)
            report_failure($sformatf("read response %b, expected OKAY", rresp));
         if (expected_reads.size() == 0)
            report_failure("read response with no read outstanding");
         else
         begin
            if (rdata !== expected_reads[0])
               report_failure($sformatf("read data %h, expected %h", rdata, expected_reads[0]));
            void'(expected_reads.pop_front());
         end
      end
      held_valid <= rvalid && !rready;
      held_data <= rdata;
   end

endmodule

//--- verification/tb_vchess_ctrl.sv
`timescale 1ns/10ps

module tb_vchess_ctrl;

   logic clk;
   logic reset;
   logic [vchess_ctrl_pkg::AXI_ADDR_WIDTH-1:0] awaddr;
   logic [vchess_ctrl_pkg::AXI_ADDR_WIDTH-1:0] araddr;
   logic [2:0] awprot, arprot;
   logic [3:0] wstrb;
   logic [31:0] wdata, rdata;
   logic [1:0] bresp, rresp;
   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rvalid, rready;
   logic soft_reset, new_board_valid, clear_moves, quiescence_moves, white_to_move;
   logic [3:0] castle_mask, en_passant_col;
   logic [vchess_ctrl_pkg::MOVE_INDEX_WIDTH-1:0] move_index, am_move_count;
   logic [vchess_ctrl_pkg::HALF_MOVE_WIDTH-1:0] half_move;
   logic [vchess_ctrl_pkg::BOARD_WIDTH-1:0] new_board;
   logic am_idle, am_moves_ready, am_move_ready, initial_mate, initial_stalemate;
   logic initial_thrice_rep, initial_fifty_move, initial_insufficient_material;
   logic initial_board_check;
   logic signed [vchess_ctrl_pkg::EVAL_WIDTH-1:0] initial_eval, am_eval;
   logic [vchess_ctrl_pkg::UCI_WIDTH-1:0] am_uci;
   int run_errors = 0; // Timeouts and pattern file problems

   vchess_ctrl dut0 (.*);
   ctrl_checker chk0 (.*);

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [vchess_ctrl_pkg::AXI_ADDR_WIDTH-1:0] byte_address
   (
      input logic [vchess_ctrl_pkg::REG_INDEX_WIDTH-1:0] index
   );
      byte_address = '0;
      byte_address[15:2] = index;
   endfunction

   function automatic logic channel_done(input int channel);
      case (channel)
         0: channel_done = awvalid && awready;
         1: channel_done = wvalid && wready;
         2: channel_done = bvalid && bready;
         3: channel_done = arvalid && arready;
         default: channel_done = rvalid && rready;
      endcase
   endfunction

   // Returns on the handshake edge
   task automatic wait_channel(input int channel, input string name);
      int n;
      n = 0;
      do
      begin
         @(posedge clk);
         n++;
      end
      while (!channel_done(channel) && n < 50);
      if (!channel_done(channel))
      begin
         run_errors++;
         $display("Timeout: no %s handshake within 50 cycles at %0t", name, $time);
      end
   endtask

   task automatic do_write(input logic [13:0] index, input logic [31:0] data);
      int aw_delay;
      int w_delay;
      aw_delay = $urandom_range(0, 3); // Picks the AW/W order
      w_delay = $urandom_range(0, 3);
      fork
         begin
            repeat (aw_delay) @(posedge clk);
            awaddr <= byte_address(index);
            awvalid <= 1'b1;
            wait_channel(0, "write address");
            awvalid <= 1'b0;
         end
         begin
            repeat (w_delay) @(posedge clk);
            wdata <= data;
            wvalid <= 1'b1;
            wait_channel(1, "write data");
            wvalid <= 1'b0;
         end
      join
      repeat ($urandom_range(0, 5)) @(posedge clk); // B stall
      bready <= 1'b1;
      wait_channel(2, "write response");
      bready <= 1'b0;
   endtask

   task automatic do_read(input logic [13:0] index, input logic [31:0] expected);
      chk0.expect_read(expected);
      araddr <= byte_address(index);
      arvalid <= 1'b1;
      wait_channel(3, "read address");
      arvalid <= 1'b0;
      repeat ($urandom_range(0, 4)) @(posedge clk); // R stall
      rready <= 1'b1;
      wait_channel(4, "read data");
      rready <= 1'b0;
   endtask

   task automatic set_status(input logic [13:0] index, input logic [31:0] value);
      case (index)
         vchess_ctrl_pkg::REG_CONTROL:
         begin
            am_moves_ready <= value[2];
            am_move_ready <= value[3];
            initial_stalemate <= value[4];
            initial_mate <= value[5];
            initial_thrice_rep <= value[6];
            am_idle <= value[7];
            initial_fifty_move <= value[8];
            initial_insufficient_material <= value[9];
            initial_board_check <= value[10];
         end
         vchess_ctrl_pkg::REG_MOVE_EVAL: am_eval <= value[23:0];
         vchess_ctrl_pkg::REG_MOVE_COUNT: am_move_count <= value[6:0];
         vchess_ctrl_pkg::REG_INITIAL_EVAL: initial_eval <= value[23:0];
         vchess_ctrl_pkg::REG_UCI: am_uci <= value[15:0];
         default:
         begin
            run_errors++;
            $display("Pattern file names unknown status index %0d", index);
         end
      endcase
   endtask

   initial
   begin
      int fd;
      int count;
      int seed;
      logic [63:0] op;
      logic [15:0] index;
      logic [31:0] value;
      logic [8*120-1:0] rest;
      seed = 85;
      seed = $urandom(seed);
      reset = 1'b1;
      awaddr = '0;
      awprot = '0;
      awvalid = 1'b0;
      wdata = '0;
      wstrb = 4'hf;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arprot = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      {am_idle, am_moves_ready, am_move_ready, initial_mate, initial_stalemate} = '0;
      {initial_thrice_rep, initial_fifty_move, initial_insufficient_material} = '0;
      initial_board_check = 1'b0;
      am_move_count = '0;
      initial_eval = '0;
      am_eval = '0;
      am_uci = '0;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      chk0.check_idle();
      fd = $fopen("verification/ctrl_patterns.txt", "r");
      if (fd == 0)
      begin
         run_errors++;
         $display("Could not open verification/ctrl_patterns.txt");
      end
      else
      begin
         while (run_errors == 0 && !$feof(fd))
         begin
            count = $fscanf(fd, "%s", op);
            if (count != 1)
               break;
            if (op == "#")
               count = $fgets(rest, fd); // Comment line
            else
            begin
               count = $fscanf(fd, "%h %h", index, value);
               if (count != 2)
               begin
                  run_errors++;
                  $display("Pattern line after op %s is malformed", op);
               end
               @(posedge clk);
               case (op)
                  "W": do_write(index[13:0], value);
                  "R": do_read(index[13:0], value);
                  "S": set_status(index[13:0], value);
                  "O": chk0.check_outputs(index, value);
                  default:
                  begin
                     run_errors++;
                     $display("Pattern file has unknown op %s", op);
                  end
               endcase
            end
         end
         $fclose(fd);
      end
      $display("Value errors: %0d, other errors: %0d", chk0.errors, run_errors);
      if (chk0.errors == 0 && run_errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

//--- verification/ctrl_patterns.txt
# op index value, all hex. W write, R read and expect, S set status input at that index
# O expect control outputs grouped as the register at that index
O 0000 00000000
O 0001 00000000
O 0002 00000000
O 0003 00000000
O 0004 00000000
O 0008 00000000
O 000F 00000000
W 0001 0000005A
O 0001 0000005A
R 0001 0000005A
W 0002 0000011A
O 0002 0000011A
R 0002 0000011A
W 0003 00000031
O 0003 00000031
R 0003 00000031
W 0004 00000001
O 0004 00000001
R 0004 00000001
W 0000 80000003
O 0000 80000003
S 0000 000007FC
R 0000 800007FF
W 0000 00000000
S 0000 00000154
R 0000 00000154
W 0008 DEADBEEF
W 000F 12345678
O 0008 DEADBEEF
O 000F 12345678
R 0008 DEADBEEF
R 000F 12345678
R 0009 00000000
S 0087 00000055
R 0087 00000055
S 0088 00FFFF38
R 0088 FFFFFF38
S 0086 0000012C
R 0086 0000012C
S 008B 0000B2D5
R 008B 000B1325
R 0005 00000000
R 0100 00000000

//--- vchess_ctrl.f
source/vchess_ctrl_pkg.sv
source/ctrl_regs_if.sv
source/axi_lite_write.sv
source/control_regs.sv
source/status_read.sv
source/vchess_ctrl.sv
verification/ctrl_checker.sv
verification/tb_vchess_ctrl.sv

//--- Bender.yml
package:
  name: vchess_ctrl

sources:
  - files:
      - source/vchess_ctrl_pkg.sv
      - source/ctrl_regs_if.sv
      - source/axi_lite_write.sv
      - source/control_regs.sv
      - source/status_read.sv
      - source/vchess_ctrl.sv
  - target: test
    files:
      - verification/ctrl_checker.sv
      - verification/tb_vchess_ctrl.sv
